//--- sim.f
+incdir+common
common/stream_pkg.sv
common/fifo_if.sv
fifo/ram_simple_dualport.sv
fifo/fifo_sync.sv
src/credit_ingress.sv
src/credit_egress.sv
src/credit_buffer_top.sv
tb/credit_buffer_tb.sv

//--- Makefile
# Verilator build and run of the credit buffer testbench

TOP := credit_buffer_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/credit_buffer_tb.sv
// credit buffer testbench with stimulus table, lfsr data, scoreboard queue, checks and watchdog
`timescale 1ns/1ps
`include "stream_consts.svh"

module credit_buffer_tb;

    localparam int DEPTH        = 2 ** `FIFO_PTR_BITS;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 8;
    localparam int NUM_ROWS     = 7;
    localparam int ROW_BUDGET   = 40;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + ROW_BUDGET * NUM_ROWS) * CLK_PERIOD;

    // ------------------------------
    // stimulus table
    // ------------------------------

    // words sent, downstream credits, one word without credit, level once idle
    int row_words   [NUM_ROWS] = '{0, 12, 16, 16, 0, 10, 0};
    int row_credits [NUM_ROWS] = '{0, 12, 16, 0, 10, 0, 16};
    bit row_bad     [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 1};
    int row_level   [NUM_ROWS] = '{0, 0, 0, 16, 6, 16, 0};

    logic              clk = 1'b0;
    logic              reset;
    logic              up_valid;
    stream_pkg::data_t up_data;
    logic              up_credit;
    logic              down_credit;
    logic              down_valid;
    stream_pkg::data_t down_data;
    logic              protocol_error;
    stream_pkg::size_t level;

    // source model and scoreboard
    stream_pkg::data_t sent_q [$];
    stream_pkg::data_t expected_word;
    logic [31:0]       lfsr_state = 32'h1d61_e12a;
    int                src_credits;
    int                total_granted;
    int                total_sent;
    int                delivered_total;
    bit                activity;
    bit                bad_sent;
    bit                error_seen;

    always #(CLK_PERIOD / 2) clk = ~clk;

    credit_buffer_top credit_buffer_top_i (
        .clk            (clk),
        .reset          (reset),
        .up_valid       (up_valid),
        .up_data        (up_data),
        .up_credit      (up_credit),
        .down_credit    (down_credit),
        .down_valid     (down_valid),
        .down_data      (down_data),
        .protocol_error (protocol_error),
        .level          (level)
    );

    // ------------------------------
    // helpers
    // ------------------------------

    task automatic stop_with_failure;
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        stop_with_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
            stop_with_failure();
        end
    endtask

    // galois form, shifts right
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    // one lfsr step per data bit
    function automatic stream_pkg::data_t random_word();
        stream_pkg::data_t word;
        int                b;
        word = '0;
        for (b = 0; b < $bits(word); b++) begin
            word       = {word[$bits(word)-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return word;
    endfunction

    // ------------------------------
    // monitor, mid cycle sampling
    // ------------------------------

    always @(negedge clk) begin
        if (!reset) begin
            if (up_credit) begin
                activity = 1'b1;
                total_granted++;
                src_credits++;
                if (src_credits > DEPTH) begin
                    report_failure("up_credit granted more credits than the FIFO depth");
                end
            end
            if (down_valid) begin
                activity = 1'b1;
                if (sent_q.size() == 0) begin
                    report_failure("down_valid seen with no word waiting in the scoreboard");
                end else begin
                    expected_word = sent_q.pop_front();
                    check_value("down_data", down_data, expected_word);
                    delivered_total++;
                end
            end
            // sticky once raised
            if (error_seen) begin
                check_value("protocol_error", protocol_error, 1);
            end else if (!bad_sent) begin
                check_value("protocol_error", protocol_error, 0);
            end
            if (protocol_error) begin
                error_seen = 1'b1;
            end
        end
    end

    // ------------------------------
    // table rows
    // ------------------------------

    task automatic run_row(input int idx);
        int                sent;
        int                given;
        int                idle;
        int                first_delivered;
        bit                counts_done;
        stream_pkg::data_t word;
        sent            = 0;
        given           = 0;
        idle            = 0;
        first_delivered = delivered_total;
        while (idle < IDLE_CYCLES) begin
            @(posedge clk);
            #1;
            up_valid    = 1'b0;
            down_credit = 1'b0;
            if (sent < row_words[idx] && src_credits > 0) begin
                word     = random_word();
                up_valid = 1'b1;
                up_data  = word;
                sent_q.push_back(word);
                src_credits--;
                total_sent++;
                sent++;
            end
            // first pop has freed a slot, its credit is not granted yet
            if (row_bad[idx] && !bad_sent && given == 2) begin
                // source holds nothing, so the buffer must refuse this word
                check_value("source_credits", src_credits, 0);
                up_valid = 1'b1;
                up_data  = random_word();
                bad_sent = 1'b1;
            end
            if (given < row_credits[idx]) begin
                down_credit = 1'b1;
                given++;
            end
            counts_done = (sent == row_words[idx]) && (given == row_credits[idx])
                       && (delivered_total - first_delivered >= row_credits[idx]);
            if (counts_done && !activity && !up_valid && !down_credit) begin
                idle++;
            end else begin
                idle = 0;
            end
            activity = 1'b0;
        end
        // design is quiet here
        check_value("level", level, row_level[idx]);
        check_value("words_delivered", delivered_total - first_delivered, row_credits[idx]);
        check_value("scoreboard_words", sent_q.size(), row_level[idx]);
        check_value("credit_balance", total_granted - total_sent, DEPTH - row_level[idx]);
        check_value("protocol_error", protocol_error, bad_sent);
    endtask

    initial begin
        reset       = 1'b1;
        up_valid    = 1'b0;
        up_data     = '0;
        down_credit = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        check_value("up_credit", up_credit, 0);
        check_value("down_valid", down_valid, 0);
        check_value("protocol_error", protocol_error, 0);
        check_value("level", level, 0);
        reset = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Test OK");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the stimulus table finished");
    end

endmodule

//--- src/credit_buffer_top.sv
// credit_buffer_top, ingress, fifo and egress joined through one fifo_if
`timescale 1ns/1ps
`include "stream_consts.svh"

module credit_buffer_top (
    input  logic              clk,
    input  logic              reset,

    // upstream source
    input  logic              up_valid,
    input  stream_pkg::data_t up_data,
    output logic              up_credit,

    // downstream sink
    input  logic              down_credit,
    output logic              down_valid,
    output stream_pkg::data_t down_data,

    // status
    output logic              protocol_error,
    output stream_pkg::size_t level
);

    fifo_if fifo_bus ();

    // ------------------------------
    // write side
    // ------------------------------

    credit_ingress credit_ingress_i (
        .clk            (clk),
        .reset          (reset),
        .up_valid       (up_valid),
        .up_data        (up_data),
        .up_credit      (up_credit),
        .protocol_error (protocol_error),
        .fifo           (fifo_bus.writer)
    );

    // ------------------------------
    // storage
    // ------------------------------

    fifo_sync #(
        .PTR_BITS (`FIFO_PTR_BITS)
    ) fifo_sync_i (
        .clk   (clk),
        .reset (reset),
        .port  (fifo_bus.fifo)
    );

    // ------------------------------
    // read side
    // ------------------------------

    credit_egress credit_egress_i (
        .clk         (clk),
        .reset       (reset),
        .down_credit (down_credit),
        .down_valid  (down_valid),
        .down_data   (down_data),
        .fifo        (fifo_bus.reader)
    );

    assign level = fifo_bus.rd_data_size;

endmodule

//--- src/credit_egress.sv
// credit_egress, downstream credit counter, fifo pop and delivery of popped words
`timescale 1ns/1ps

module credit_egress (
    input  logic              clk,
    input  logic              reset,

    input  logic              down_credit,
    output logic              down_valid,
    output stream_pkg::data_t down_data,

    fifo_if.reader            fifo
);

    // ------------------------------
    // downstream credits
    // ------------------------------

    stream_pkg::credit_t credit_cnt;

    logic pop;

    // a credit arriving now is only usable next cycle
    assign pop = (credit_cnt != '0) && !fifo.rd_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= '0;
        end else begin
            case ({down_credit, pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // ------------------------------
    // read and delivery
    // ------------------------------

    assign fifo.rd_en = pop;

    // ram output lands one cycle after the pop
    always_ff @(posedge clk) begin
        if (reset) begin
            down_valid <= 1'b0;
        end else begin
            down_valid <= pop;
        end
    end

    assign down_data = fifo.rd_data;

endmodule

//--- src/credit_ingress.sv
// credit_ingress, upstream credit grant from fifo free space and fifo write of arriving words
`timescale 1ns/1ps

module credit_ingress (
    input  logic              clk,
    input  logic              reset,

    input  logic              up_valid,
    input  stream_pkg::data_t up_data,
    output logic              up_credit,
    output logic              protocol_error,

    fifo_if.writer            fifo
);

    // ------------------------------
    // credit bookkeeping
    // ------------------------------

    // granted but not yet used by an arriving word
    stream_pkg::credit_t outstanding;

    logic have_credit;
    logic accept;
    logic grant;

    assign have_credit = (outstanding != '0);
    assign accept      = up_valid && have_credit;

    // free space already counts every outstanding credit
    assign grant = !fifo.wr_full && (fifo.wr_free_size > outstanding);

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= '0;
        end else begin
            case ({grant, accept})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // one pulse per granted word
    always_ff @(posedge clk) begin
        if (reset) begin
            up_credit <= 1'b0;
        end else begin
            up_credit <= grant;
        end
    end

    // ------------------------------
    // write path
    // ------------------------------

    assign fifo.wr_en   = accept;
    assign fifo.wr_data = up_data;

    // word without credit is dropped, error stays set
    always_ff @(posedge clk) begin
        if (reset) begin
            protocol_error <= 1'b0;
        end else if (up_valid && !have_credit) begin
            protocol_error <= 1'b1;
        end
    end

endmodule

//--- fifo/fifo_sync.sv
// fifo_sync, synchronous fifo with wrap bit pointers and registered full, empty and counts
`timescale 1ns/1ps
`include "stream_consts.svh"

module fifo_sync #(
    parameter int PTR_BITS = `FIFO_PTR_BITS
) (
    input  logic clk,
    input  logic reset,
    fifo_if.fifo port
);

    localparam int DEPTH     = 2 ** PTR_BITS;
    localparam int DATA_BITS = $bits(stream_pkg::data_t);

    // extra top bit tells full from empty when the address bits match
    typedef logic [PTR_BITS:0] ptr_t;

    // ------------------------------
    // pointers
    // ------------------------------

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    ptr_t next_wr_ptr;
    ptr_t next_rd_ptr;

    // ------------------------------
    // storage
    // ------------------------------

    logic                 ram_wr_en;
    logic                 ram_rd_en;
    logic [DATA_BITS-1:0] ram_rd_data;

    ram_simple_dualport #(
        .ADDR_BITS (PTR_BITS),
        .DATA_BITS (DATA_BITS)
    ) ram_i (
        .clk     (clk),
        .wr_en   (ram_wr_en),
        .wr_addr (wr_ptr[PTR_BITS-1:0]),
        .wr_din  (port.wr_data),
        .rd_en   (ram_rd_en),
        .rd_addr (rd_ptr[PTR_BITS-1:0]),
        .rd_dout (ram_rd_data)
    );

    // registered status
    logic full_q;
    ptr_t free_q;
    logic empty_q;
    ptr_t fill_q;

    // next status from both next pointers
    logic next_full;
    ptr_t next_free;
    logic next_empty;
    ptr_t next_fill;

    assign ram_wr_en = port.wr_en && !full_q;
    assign ram_rd_en = port.rd_en && !empty_q;

    assign next_wr_ptr = wr_ptr + ptr_t'(ram_wr_en);
    assign next_rd_ptr = rd_ptr + ptr_t'(ram_rd_en);

    always_comb begin
        next_fill  = next_wr_ptr - next_rd_ptr;
        next_free  = ptr_t'(DEPTH) - next_fill;
        next_empty = (next_wr_ptr == next_rd_ptr);
        next_full  = (next_wr_ptr[PTR_BITS] != next_rd_ptr[PTR_BITS])
                  && (next_wr_ptr[PTR_BITS-1:0] == next_rd_ptr[PTR_BITS-1:0]);
    end

    // ------------------------------
    // status registers
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            // full through reset keeps writers out
            full_q  <= 1'b1;
            free_q  <= '0;
            empty_q <= 1'b1;
            fill_q  <= '0;
        end else begin
            wr_ptr  <= next_wr_ptr;
            rd_ptr  <= next_rd_ptr;
            full_q  <= next_full;
            free_q  <= next_free;
            empty_q <= next_empty;
            fill_q  <= next_fill;
        end
    end

    // ------------------------------
    // interface outputs
    // ------------------------------

    assign port.wr_full      = full_q;
    assign port.wr_free_size = stream_pkg::size_t'(free_q);
    assign port.rd_empty     = empty_q;
    assign port.rd_data_size = stream_pkg::size_t'(fill_q);
    assign port.rd_data      = ram_rd_data;

endmodule

//--- fifo/ram_simple_dualport.sv
// ram_simple_dualport, single clock memory with one write port and one registered read port
`timescale 1ns/1ps

module ram_simple_dualport #(
    parameter int ADDR_BITS = 4,
    parameter int DATA_BITS = 8
) (
    input  logic                 clk,

    input  logic                 wr_en,
    input  logic [ADDR_BITS-1:0] wr_addr,
    input  logic [DATA_BITS-1:0] wr_din,

    input  logic                 rd_en,
    input  logic [ADDR_BITS-1:0] rd_addr,
    output logic [DATA_BITS-1:0] rd_dout
);

    localparam int MEM_DEPTH = 2 ** ADDR_BITS;

    // ------------------------------
    // storage
    // ------------------------------

    logic [DATA_BITS-1:0] mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_din;
        end
    end

    // ------------------------------
    // read port
    // ------------------------------

    // output holds its last word between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_dout <= mem[rd_addr];
        end
    end

endmodule

//--- common/fifo_if.sv
// fifo_if bundling the fifo write and read sides with writer, reader and fifo modports
`timescale 1ns/1ps

interface fifo_if;

    // write side
    logic                wr_en;
    stream_pkg::data_t   wr_data;
    logic                wr_full;
    stream_pkg::size_t   wr_free_size;

    // read side, rd_data follows an accepted read by one cycle
    logic                rd_en;
    stream_pkg::data_t   rd_data;
    logic                rd_empty;
    stream_pkg::size_t   rd_data_size;

    modport writer (
        output wr_en,
        output wr_data,
        input  wr_full,
        input  wr_free_size
    );

    modport reader (
        output rd_en,
        input  rd_data,
        input  rd_empty
    );

    modport fifo (
        input  wr_en,
        input  wr_data,
        output wr_full,
        output wr_free_size,
        input  rd_en,
        output rd_data,
        output rd_empty,
        output rd_data_size
    );

endinterface

//--- common/stream_pkg.sv
// stream_pkg with the data word, entry count and credit count types
`include "stream_consts.svh"

package stream_pkg;

    // ------------------------------
    // payload
    // ------------------------------

    // one word as it is stored in the fifo
    typedef logic [`DATA_BITS-1:0] data_t;

    // ------------------------------
    // counts
    // ------------------------------

    // entries from zero up to the full depth, one bit above the address
    typedef logic [`FIFO_PTR_BITS:0] size_t;

    // granted or received credits
    typedef logic [`CREDIT_BITS-1:0] credit_t;

endpackage

//--- common/stream_consts.svh
// width and depth macros for the credit buffer datapath
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// ------------------------------
// datapath
// ------------------------------

// bits in one stream word
`define DATA_BITS 8

// ------------------------------
// fifo and credits
// ------------------------------

// address bits, depth is 2**FIFO_PTR_BITS
`define FIFO_PTR_BITS 4

// must hold the full fifo depth
`define CREDIT_BITS 5

`endif
